// ==== all.f ====
+incdir+.
fpuFormatPkg.sv
fpuControlPkg.sv
fpuMultiplier16.sv
fpuNormalizer16.sv
fpuMul16.sv
fpuResultBank.sv
fpuCoproc.sv
tbClock.sv
tbFpuCoproc.sv

// ==== fpuControlPkg.sv ====
// Coprocessor control types
`include "fpu_config.svh"

package fpuControlPkg;

  // Lane sequencing.
  typedef enum logic [1:0] {
    WAIT,
    SIGCOMP,
    DONE
  } laneState_t;

  // Result register select.
  typedef logic [$clog2(`FPU_REGS)-1:0] regIndex_t;

  // Lane select, used by the write arbiter.
  typedef logic [$clog2(`FPU_LANES)-1:0] laneIndex_t;

endpackage

// ==== fpuCoproc.sv ====
// Dual-lane FP16 multiply coprocessor
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpuCoproc
  import fpuFormatPkg::*, fpuControlPkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          start0,
  input  logic          start1,
  input  fp16_t         operandA0,
  input  fp16_t         operandB0,
  input  fp16_t         operandA1,
  input  fp16_t         operandB1,
  input  regIndex_t     dest0,
  input  regIndex_t     dest1,
  output logic          busy0,
  output logic          busy1,
  input  regIndex_t     readAddr,
  output fp16_t         readValue,
  output opStatusFlag_t readFlags,
  output condCode_t     readCodes
);
  // Lane to bank results, one slot per lane.
  logic [`FPU_LANES-1:0]          resultValid;
  logic [`FPU_LANES-1:0]          writeGrant;
  fp16_t [`FPU_LANES-1:0]         resultValue;
  opStatusFlag_t [`FPU_LANES-1:0] resultFlags;
  condCode_t [`FPU_LANES-1:0]     resultCodes;
  regIndex_t [`FPU_LANES-1:0]     resultDest;

  fpuMul16 lane0 (
    .clock(clock), .reset(reset), .start(start0),
    .fpuIn1(operandA0), .fpuIn2(operandB0), .dest(dest0),
    .writeGrant(writeGrant[0]), .busy(busy0),
    .resultValid(resultValid[0]), .resultValue(resultValue[0]),
    .resultFlags(resultFlags[0]), .resultCodes(resultCodes[0]),
    .resultDest(resultDest[0])
  );

  fpuMul16 lane1 (
    .clock(clock), .reset(reset), .start(start1),
    .fpuIn1(operandA1), .fpuIn2(operandB1), .dest(dest1),
    .writeGrant(writeGrant[1]), .busy(busy1),
    .resultValid(resultValid[1]), .resultValue(resultValue[1]),
    .resultFlags(resultFlags[1]), .resultCodes(resultCodes[1]),
    .resultDest(resultDest[1])
  );

  fpuResultBank resultBank (
    .clock       (clock),
    .reset       (reset),
    .resultValid (resultValid),
    .resultValue (resultValue),
    .resultFlags (resultFlags),
    .resultCodes (resultCodes),
    .resultDest  (resultDest),
    .writeGrant  (writeGrant),
    .readAddr    (readAddr),
    .readValue   (readValue),
    .readFlags   (readFlags),
    .readCodes   (readCodes)
  );

endmodule

// ==== fpuFormatPkg.sv ====
// Half-precision number format types
`include "fpu_config.svh"

package fpuFormatPkg;

  // Sign at the top, then exponent, then fraction.
  typedef logic [`FP16_EXPW+`FP16_FRACW:0] fp16_t;

  // Significand including the hidden bit.
  typedef logic [`FP16_FRACW:0] sig11_t;

  // Zero, carry, negative, overflow, from the top bit down.
  typedef logic [3:0] condCode_t;

  // Overflow, underflow, inexact, from the top bit down.
  typedef logic [2:0] opStatusFlag_t;

  function automatic logic fpSign(fp16_t value);
    return value[`FP16_EXPW+`FP16_FRACW];
  endfunction

  function automatic logic [`FP16_EXPW-1:0] fpExp(fp16_t value);
    return value[`FP16_FRACW +: `FP16_EXPW];
  endfunction

  function automatic logic [`FP16_FRACW-1:0] fpFrac(fp16_t value);
    return value[`FP16_FRACW-1:0];
  endfunction

endpackage

// ==== fpuMul16.sv ====
// FP16 multiply lane
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpuMul16
  import fpuFormatPkg::*, fpuControlPkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          start,
  input  fp16_t         fpuIn1,
  input  fp16_t         fpuIn2,
  input  regIndex_t     dest,
  input  logic          writeGrant,
  output logic          busy,
  output logic          resultValid,
  output fp16_t         resultValue,
  output opStatusFlag_t resultFlags,
  output condCode_t     resultCodes,
  output regIndex_t     resultDest
);
  localparam fp16_t quietNaN = {1'b0, {`FP16_EXPW{1'b1}}, 1'b1, {(`FP16_FRACW-1){1'b0}}};

  laneState_t                 state;
  laneState_t                 nextState;
  fp16_t                      opA;
  fp16_t                      opB;
  regIndex_t                  destReg;
  logic                       accept;
  sig11_t                     sigIn1;
  sig11_t                     sigIn2;
  logic [2*`FP16_FRACW+1:0]   product;
  logic                       mulDone;
  logic [`FP16_EXPW:0]        expSum;
  logic [`FP16_EXPW:0]        biasedExp;
  logic [`FP16_EXPW:0]        denormDiff;
  logic [`FP16_EXPW-1:0]      unnormExp;
  logic                       denorm;
  logic                       OFin;
  logic                       sticky;
  logic                       nanIn;
  fp16_t                      normOut;
  opStatusFlag_t              normFlags;

  assign accept = start && (state == WAIT);

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= WAIT;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      WAIT:    if (start) nextState = SIGCOMP;
      SIGCOMP: if (mulDone) nextState = DONE;
      DONE:    if (writeGrant) nextState = WAIT;
      default: nextState = WAIT;
    endcase
  end

  // Operands and destination are held for the whole operation.
  always_ff @(posedge clock) begin
    if (accept) begin
      opA <= fpuIn1;
      opB <= fpuIn2;
      destReg <= dest;
    end
  end

  // The multiplier loads on the start edge, so it sees the ports directly.
  assign sigIn1 = {fpExp(fpuIn1) != '0, fpFrac(fpuIn1)};
  assign sigIn2 = {fpExp(fpuIn2) != '0, fpFrac(fpuIn2)};

  fpuMultiplier16 sigMultiplier (
    .clock  (clock),
    .reset  (reset),
    .start  (accept),
    .mulIn1 (sigIn1),
    .mulIn2 (sigIn2),
    .mulOut (product),
    .done   (mulDone)
  );

  // Biased exponent sum, and whether it lands below or above the normal range.
  assign expSum = {1'b0, fpExp(opA)} + {1'b0, fpExp(opB)};
  assign biasedExp = expSum - (`FP16_EXPW+1)'(`FP16_BIAS);
  assign denorm = (expSum < (`FP16_EXPW+1)'(`FP16_BIAS));
  assign OFin = !denorm && (biasedExp > (`FP16_EXPW+1)'(`FP16_EXP_MAX));
  assign unnormExp = denorm ? '0 : biasedExp[`FP16_EXPW-1:0];
  assign denormDiff = denorm ? (`FP16_EXPW+1)'(`FP16_BIAS) - expSum : '0;

  // Bits below the guard position.
  assign sticky = (product[`FP16_FRACW-2:0] != '0);

  fpuNormalizer16 mulNormalizer (
    .unnormSign    (fpSign(opA) ^ fpSign(opB)),
    .unnormInt     (product[2*`FP16_FRACW+1 -: 2]),
    .unnormFrac    (product[2*`FP16_FRACW-1:0]),
    .unnormExp     (unnormExp),
    .denormDiff    (denormDiff),
    .sticky        (sticky),
    .OFin          (OFin),
    .normOut       (normOut),
    .opStatusFlags (normFlags)
  );

  assign nanIn = ((fpExp(opA) == '1) && (fpFrac(opA) != '0)) ||
                 ((fpExp(opB) == '1) && (fpFrac(opB) != '0));

  assign busy = (state != WAIT);
  assign resultValid = (state == DONE);
  assign resultDest = destReg;
  assign resultValue = nanIn ? quietNaN : normOut;
  assign resultFlags = nanIn ? '0 : normFlags;
  // Carry and overflow codes stay low.
  assign resultCodes = {(resultValue[`FP16_EXPW+`FP16_FRACW-1:0] == '0), 1'b0,
                        fpSign(resultValue), 1'b0};

endmodule

// ==== fpuMultiplier16.sv ====
// Shift-add significand multiplier
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpuMultiplier16 (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start,
  input  logic [`FP16_FRACW:0]     mulIn1,
  input  logic [`FP16_FRACW:0]     mulIn2,
  output logic [2*`FP16_FRACW+1:0] mulOut,
  output logic                     done
);
  localparam int sigW = `FP16_FRACW + 1;
  localparam int prodW = 2 * sigW;

  logic [prodW-1:0]        multiplicand;
  logic [prodW-1:0]        accumulator;
  logic [sigW-1:0]         multiplier;
  logic [$clog2(sigW)-1:0] bitCount;
  logic                    running;

  // One multiplier bit per cycle, done after the last one.
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      running <= 1'b0;
      bitCount <= '0;
      done <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
      bitCount <= '0;
      done <= 1'b0;
    end else if (running) begin
      bitCount <= bitCount + 1'b1;
      if (bitCount == sigW - 1) begin
        running <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Accumulate the shifted multiplicand for each set multiplier bit.
  always_ff @(posedge clock) begin
    if (start) begin
      multiplicand <= {{sigW{1'b0}}, mulIn1};
      multiplier <= mulIn2;
      accumulator <= '0;
    end else if (running) begin
      if (multiplier[0]) begin
        accumulator <= accumulator + multiplicand;
      end
      multiplicand <= multiplicand << 1;
      multiplier <= multiplier >> 1;
    end
  end

  // Product stays here until the next start.
  assign mulOut = accumulator;

endmodule

// ==== fpuNormalizer16.sv ====
// FP16 product normalizer and rounder
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpuNormalizer16
  import fpuFormatPkg::*;
(
  input  logic                     unnormSign,
  input  logic [1:0]               unnormInt,
  input  logic [2*`FP16_FRACW-1:0] unnormFrac,
  input  logic [`FP16_EXPW-1:0]    unnormExp,
  input  logic [`FP16_EXPW:0]      denormDiff,
  input  logic                     sticky,
  input  logic                     OFin,
  output fp16_t                    normOut,
  output opStatusFlag_t            opStatusFlags
);
  localparam int fracW = `FP16_FRACW;
  localparam int expW = `FP16_EXPW;
  // Two integer bits, kept fraction, guard and sticky.
  localparam int workW = fracW + 4;
  // Room for the largest subnormal shift.
  localparam int padW = `FP16_BIAS + 1;

  logic [workW-1:0]        rawWork;
  logic [workW-1:0]        alignWork;
  logic [workW-1:0]        subWork;
  logic [workW+padW-1:0]   shiftedWork;
  logic signed [expW+1:0]  effExp;
  logic signed [expW+1:0]  alignExp;
  logic [expW:0]           subShift;
  logic [expW-1:0]         expField;
  logic [expW+fracW-1:0]   packedMag;
  logic [expW+fracW-1:0]   rounded;
  logic                    subnormal;
  logic                    guardBit;
  logic                    stickyBit;
  logic                    roundUp;
  logic                    productZero;
  logic                    overflow;
  logic                    underflow;
  logic                    inexact;

  assign rawWork = {unnormInt, unnormFrac[2*fracW-1 -: fracW+1], sticky};

  // Signed exponent, negative when the result falls below the normal range.
  assign effExp = $signed({2'b00, unnormExp}) - $signed({1'b0, denormDiff});

  // Products of 2 or more move right one place.
  assign alignWork = unnormInt[1] ?
                     {1'b0, rawWork[workW-1:2], rawWork[1] | rawWork[0]} : rawWork;
  assign alignExp = effExp + {{(expW+1){1'b0}}, unnormInt[1]};

  // Subnormal results shift right until the exponent reaches 1.
  assign subnormal = (alignExp < 1);
  assign subShift = subnormal ? (expW+1)'(1 - alignExp) : '0;
  assign shiftedWork = {alignWork, {padW{1'b0}}} >> subShift;
  assign subWork = {shiftedWork[workW+padW-1:padW+1], |shiftedWork[padW:0]};

  assign guardBit = subWork[1];
  assign stickyBit = subWork[0];
  assign expField = subnormal ? '0 : alignExp[expW-1:0];
  assign packedMag = {expField, subWork[fracW+1:2]};

  // Round to nearest, ties to even. A carry ripples into the exponent.
  assign roundUp = guardBit & (stickyBit | subWork[2]);
  assign rounded = packedMag + {{(expW+fracW-1){1'b0}}, roundUp};

  assign productZero = (unnormInt == 2'b00) && (unnormFrac == '0) && !sticky;
  assign overflow = !productZero &&
                    (OFin || (alignExp > `FP16_EXP_MAX) || (rounded[fracW +: expW] == '1));
  assign underflow = !productZero && !overflow && (rounded[fracW +: expW] == '0);
  assign inexact = !productZero && (guardBit || stickyBit || overflow);

  always_comb begin
    if (productZero) begin
      normOut = {unnormSign, {(expW+fracW){1'b0}}};
    end else if (overflow) begin
      // Saturate to a signed infinity.
      normOut = {unnormSign, {expW{1'b1}}, {fracW{1'b0}}};
    end else begin
      normOut = {unnormSign, rounded};
    end
  end

  assign opStatusFlags = {overflow, underflow, inexact};

endmodule

// ==== fpuResultBank.sv ====
// Shared result register bank
`timescale 1ns/1ps
`include "fpu_config.svh"

module fpuResultBank
  import fpuFormatPkg::*, fpuControlPkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  logic [`FPU_LANES-1:0]          resultValid,
  input  fp16_t [`FPU_LANES-1:0]         resultValue,
  input  opStatusFlag_t [`FPU_LANES-1:0] resultFlags,
  input  condCode_t [`FPU_LANES-1:0]     resultCodes,
  input  regIndex_t [`FPU_LANES-1:0]     resultDest,
  output logic [`FPU_LANES-1:0]          writeGrant,
  input  regIndex_t                      readAddr,
  output fp16_t                          readValue,
  output opStatusFlag_t                  readFlags,
  output condCode_t                      readCodes
);
  fp16_t         regValue [`FPU_REGS];
  opStatusFlag_t regFlags [`FPU_REGS];
  condCode_t     regCodes [`FPU_REGS];
  laneIndex_t    rrPtr;
  laneIndex_t    grantIdx;
  logic          anyGrant;

  // Search from the priority lane onward, first valid lane wins.
  always_comb begin
    laneIndex_t candidate;
    writeGrant = '0;
    grantIdx = rrPtr;
    anyGrant = 1'b0;
    for (int i = 0; i < `FPU_LANES; i++) begin
      candidate = laneIndex_t'((int'(rrPtr) + i) % `FPU_LANES);
      if (!anyGrant && resultValid[candidate]) begin
        anyGrant = 1'b1;
        grantIdx = candidate;
      end
    end
    if (anyGrant) begin
      writeGrant[grantIdx] = 1'b1;
    end
  end

  // Priority passes to the lane after the one just granted.
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      rrPtr <= '0;
    end else if (anyGrant) begin
      rrPtr <= laneIndex_t'((int'(grantIdx) + 1) % `FPU_LANES);
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      for (int r = 0; r < `FPU_REGS; r++) begin
        regValue[r] <= '0;
        regFlags[r] <= '0;
        regCodes[r] <= '0;
      end
    end else if (anyGrant) begin
      regValue[resultDest[grantIdx]] <= resultValue[grantIdx];
      regFlags[resultDest[grantIdx]] <= resultFlags[grantIdx];
      regCodes[resultDest[grantIdx]] <= resultCodes[grantIdx];
    end
  end

  // Host read port.
  assign readValue = regValue[readAddr];
  assign readFlags = regFlags[readAddr];
  assign readCodes = regCodes[readAddr];

endmodule

// ==== fpu_config.svh ====
// FP16 coprocessor configuration
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Half-precision field widths.
`define FP16_EXPW 5
`define FP16_FRACW 10

// Exponent bias and the largest biased exponent of a finite value.
`define FP16_BIAS 15
`define FP16_EXP_MAX 30

// Result register bank depth.
`define FPU_REGS 8

// Number of multiply lanes sharing the bank.
`define FPU_LANES 2

`endif

// ==== tbClock.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tbClock #(
  parameter int period = 40
) (
  output logic clock,
  output logic reset
);
  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // Reset spans two rising edges and drops on a falling edge.
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// ==== tbFpuCoproc.sv ====
// FP16 coprocessor testbench
`timescale 1ns/1ps
`include "fpu_config.svh"

module tbFpuCoproc
  import fpuFormatPkg::*, fpuControlPkg::*;
();
  // Ten multiplies, 40 cycles each, plus room for reads.
  localparam int opCount = 10;
  localparam int cycleLimit = 40 * opCount + 200;

  logic          clock;
  logic          reset;
  logic          start0;
  logic          start1;
  fp16_t         operandA0;
  fp16_t         operandB0;
  fp16_t         operandA1;
  fp16_t         operandB1;
  regIndex_t     dest0;
  regIndex_t     dest1;
  logic          busy0;
  logic          busy1;
  regIndex_t     readAddr;
  fp16_t         readValue;
  opStatusFlag_t readFlags;
  condCode_t     readCodes;
  int            errorCount;
  int            checkCount;
  int            cycleCount;

  tbClock #(.period(40)) clockGen (.clock(clock), .reset(reset));

  fpuCoproc dut0 (
    .clock     (clock),
    .reset     (reset),
    .start0    (start0),
    .start1    (start1),
    .operandA0 (operandA0),
    .operandB0 (operandB0),
    .operandA1 (operandA1),
    .operandB1 (operandB1),
    .dest0     (dest0),
    .dest1     (dest1),
    .busy0     (busy0),
    .busy1     (busy1),
    .readAddr  (readAddr),
    .readValue (readValue),
    .readFlags (readFlags),
    .readCodes (readCodes)
  );

  task automatic checkEqual(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    checkCount++;
    assert (got === expected) else begin
      errorCount++;
      $display("mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  // Zero code from the magnitude, negative code from the sign.
  function automatic condCode_t codesFor(input fp16_t value);
    return {value[14:0] == 15'd0, 1'b0, value[15], 1'b0};
  endfunction

  // Reference product for normal operands whose result stays in the normal range.
  task automatic computeProduct(input fp16_t a, input fp16_t b,
                                output fp16_t value, output opStatusFlag_t flags);
    int sigA;
    int sigB;
    int prod;
    int shift;
    int kept;
    int rem;
    int half;
    int expOut;
    logic [4:0] expBits;
    logic [9:0] fracBits;
    sigA = 1024 + a[9:0];
    sigB = 1024 + b[9:0];
    prod = sigA * sigB;
    shift = (prod >= (1 << 21)) ? 11 : 10;
    kept = prod >> shift;
    rem = prod & ((1 << shift) - 1);
    half = 1 << (shift - 1);
    expOut = a[14:10] + b[14:10] - `FP16_BIAS + shift - 10;
    // Nearest, ties go to the even significand.
    if (rem > half || (rem == half && kept % 2 == 1)) begin
      kept++;
    end
    if (kept == 2048) begin
      kept = kept >> 1;
      expOut++;
    end
    expBits = expOut[4:0];
    fracBits = kept[9:0];
    value = {a[15] ^ b[15], expBits, fracBits};
    flags = {2'b00, rem != 0};
  endtask

  // Address goes out on one falling edge, the read data is checked on the next.
  task automatic readAndCheck(input regIndex_t addr, input fp16_t expValue,
                              input opStatusFlag_t expFlags, input condCode_t expCodes);
    @(negedge clock);
    readAddr = addr;
    @(negedge clock);
    checkEqual($sformatf("readValue[%0d]", addr), readValue, expValue);
    checkEqual($sformatf("readFlags[%0d]", addr), readFlags, expFlags);
    checkEqual($sformatf("readCodes[%0d]", addr), readCodes, expCodes);
  endtask

  // One-cycle start on the chosen lanes, then confirm they went busy.
  task automatic pulseStart(input bit lane0On, input bit lane1On);
    @(negedge clock);
    start0 = lane0On;
    start1 = lane1On;
    @(negedge clock);
    start0 = 1'b0;
    start1 = 1'b0;
    checkCount++;
    assert (!(lane0On && !busy0) && !(lane1On && !busy1)) else begin
      errorCount++;
      $display("A started lane did not go busy at time %0t", $time);
    end
  endtask

  task automatic waitIdle(output bit sawSplit);
    sawSplit = 1'b0;
    while (busy0 || busy1) begin
      if (busy0 != busy1) begin
        sawSplit = 1'b1;
      end
      @(negedge clock);
    end
  endtask

  task automatic laneMultiply(input int lane, input fp16_t a, input fp16_t b,
                              input regIndex_t d);
    bit split;
    if (lane == 0) begin
      operandA0 = a;
      operandB0 = b;
      dest0 = d;
      pulseStart(1'b1, 1'b0);
    end else begin
      operandA1 = a;
      operandB1 = b;
      dest1 = d;
      pulseStart(1'b0, 1'b1);
    end
    waitIdle(split);
  endtask

  task automatic checkProduct(input int lane, input fp16_t a, input fp16_t b,
                              input regIndex_t d);
    fp16_t expValue;
    opStatusFlag_t expFlags;
    computeProduct(a, b, expValue, expFlags);
    laneMultiply(lane, a, b, d);
    readAndCheck(d, expValue, expFlags, codesFor(expValue));
  endtask

  task automatic resetDefaults();
    checkEqual("busy0", busy0, 1'b0);
    checkEqual("busy1", busy1, 1'b0);
    checkEqual("resultValid", dut0.resultValid, '0);
    checkEqual("writeGrant", dut0.writeGrant, '0);
    for (int r = 0; r < `FPU_REGS; r++) begin
      readAndCheck(regIndex_t'(r), '0, '0, '0);
    end
  endtask

  task automatic exactProducts();
    // 1.5 x 2 and -2 x 0.5.
    checkProduct(0, 16'h3E00, 16'h4000, 3'd1);
    checkProduct(0, 16'hC000, 16'h3800, 3'd2);
  endtask

  task automatic zeroOperands();
    fp16_t a;
    fp16_t b;
    fp16_t expValue;
    // +0 x 5.0, then -0 x 3.0.
    a = 16'h0000;
    b = 16'h4500;
    expValue = {a[15] ^ b[15], 15'd0};
    laneMultiply(0, a, b, 3'd3);
    readAndCheck(3'd3, expValue, '0, codesFor(expValue));
    a = 16'h8000;
    b = 16'h4200;
    expValue = {a[15] ^ b[15], 15'd0};
    laneMultiply(0, a, b, 3'd4);
    readAndCheck(3'd4, expValue, '0, codesFor(expValue));
  endtask

  task automatic rangeLimits();
    // 65504 squared exceeds the format and saturates to infinity.
    laneMultiply(0, 16'h7BFF, 16'h7BFF, 3'd5);
    readAndCheck(3'd5, 16'h7C00, 3'b101, codesFor(16'h7C00));
    // 2^-28 lies under half the smallest subnormal and rounds to zero.
    laneMultiply(0, 16'h0400, 16'h0400, 3'd6);
    readAndCheck(3'd6, 16'h0000, 3'b011, codesFor(16'h0000));
  endtask

  task automatic concurrentLanes();
    regIndex_t d0;
    regIndex_t d1;
    fp16_t exp0;
    fp16_t exp1;
    opStatusFlag_t flags0;
    opStatusFlag_t flags1;
    bit split;
    d0 = regIndex_t'($urandom % `FPU_REGS);
    d1 = regIndex_t'((d0 + 1 + $urandom % (`FPU_REGS - 1)) % `FPU_REGS);
    // 1.5 x 1.5 on lane 0, -3 x 1.25 on lane 1.
    operandA0 = 16'h3E00;
    operandB0 = 16'h3E00;
    dest0 = d0;
    operandA1 = 16'hC200;
    operandB1 = 16'h3D00;
    dest1 = d1;
    computeProduct(operandA0, operandB0, exp0, flags0);
    computeProduct(operandA1, operandB1, exp1, flags1);
    pulseStart(1'b1, 1'b1);
    waitIdle(split);
    checkCount++;
    assert (split) else begin
      errorCount++;
      $display("Both lanes left busy together, the bank granted two writes at once");
    end
    readAndCheck(d0, exp0, flags0, codesFor(exp0));
    readAndCheck(d1, exp1, flags1, codesFor(exp1));
  endtask

  task automatic roundingCases();
    // (1 + 2^-10) squared, then 1.0009765625 x 1.5 which sits on a tie.
    checkProduct(0, 16'h3C01, 16'h3C01, 3'd7);
    checkProduct(1, 16'h3C01, 16'h3E00, 3'd0);
  endtask

  initial begin
    void'($urandom(65826));
    errorCount = 0;
    checkCount = 0;
    start0 = 1'b0;
    start1 = 1'b0;
    operandA0 = '0;
    operandB0 = '0;
    operandA1 = '0;
    operandB1 = '0;
    dest0 = '0;
    dest1 = '0;
    readAddr = '0;
    @(negedge reset);
    @(negedge clock);
    resetDefaults();
    exactProducts();
    zeroOperands();
    rangeLimits();
    concurrentLanes();
    roundingCases();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, a lane never went idle", cycleLimit);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    $display("Errors found");
    $finish;
  end

endmodule
